//--- src/spi_arb_pkg.sv
//====================================================================
// arbitration constants and controller types for the spi requester
// interconnect, imported by the controller, datapath and top level
//====================================================================
`default_nettype none

package spi_arb_pkg;

    //================================================================
    // port count
    //================================================================
    // requester ports sharing the one master
    localparam int num_ports = 8;
    localparam int port_w    = $clog2(num_ports);

    // index of one requester port
    typedef logic [port_w-1:0] port_idx_t;

    // one bit per requester port
    typedef logic [num_ports-1:0] port_vec_t;

    //================================================================
    // grant fsm
    //================================================================
    // scan polls one port per clock, issue waits for master busy,
    // exec waits for busy to drop, done pulses finish
    typedef enum logic [2:0] {
        idle,
        scan,
        issue,
        exec,
        done
    } grant_state_t;

    // controller to datapath
    typedef struct packed {
        port_idx_t port;
        logic      capture;
        logic      issue;
        logic      active;
    } grant_ctl_t;

endpackage

`default_nettype wire

//--- src/spi_req_pkg.sv
//====================================================================
// spi request fields and data beat types shared by the requester and
// master sides of the interconnect
//====================================================================
`default_nettype none

package spi_req_pkg;

    // port count comes from the arbitration package
    import spi_arb_pkg::num_ports;

    //================================================================
    // widths
    //================================================================
    // transfer length in bytes
    localparam int len_w  = 24;
    // spi opcode
    localparam int cmd_w  = 8;
    // one stream beat
    localparam int data_w = 8;

    typedef logic [len_w-1:0]  len_t;
    typedef logic [cmd_w-1:0]  cmd_t;
    typedef logic [data_w-1:0] data_t;

    //================================================================
    // request and stream bundles
    //================================================================
    // total length, write length, command, 56 bits
    typedef struct packed {
        len_t req_len;
        len_t req_wr_len;
        cmd_t req_cmd;
    } spi_req_t;

    // one beat per requester port
    typedef data_t [num_ports-1:0] data_arr_t;

    // request fields of every requester port
    typedef spi_req_t [num_ports-1:0] req_arr_t;

endpackage

`default_nettype wire

//--- src/spi_grant_ctrl.sv
//====================================================================
// round-robin grant controller, polls one requester per clock and
// steers the datapath through grant_ctl_t
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module spi_grant_ctrl (
    input  wire                     m0,
    input  wire                     rst_n,
    input  spi_arb_pkg::port_vec_t  request,
    input  wire                     m_busy,
    output spi_arb_pkg::grant_ctl_t ctl,
    output spi_arb_pkg::port_vec_t  finish,
    output spi_arb_pkg::port_vec_t  busy
);

    import spi_arb_pkg::*;

    grant_state_t state;
    grant_state_t state_nxt;
    // polled port in scan, granted port from issue to done
    port_idx_t    ptr;
    port_vec_t    ptr_onehot;
    port_vec_t    busy_q;

    assign ptr_onehot = port_vec_t'(1) << ptr;

    //================================================================
    // state machine
    //================================================================
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: state_nxt = scan;
            // grant the first pending port seen
            scan: begin
                if (request[ptr]) begin
                    state_nxt = issue;
                end
            end
            // master has taken the command
            issue: begin
                if (m_busy) begin
                    state_nxt = exec;
                end
            end
            // transfer over
            exec: begin
                if (!m_busy) begin
                    state_nxt = done;
                end
            end
            done:    state_nxt = scan;
            default: state_nxt = idle;
        endcase
    end

    // pointer moves on an empty poll and after a grant,
    // frozen while a port holds the master
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if ((state == scan && !request[ptr]) || state == done) begin
            ptr <= ptr + port_idx_t'(1);
        end
    end

    //================================================================
    // datapath control
    //================================================================
    always_comb begin
        ctl.port    = ptr;
        ctl.capture = (state == scan) && request[ptr];
        ctl.issue   = (state == issue);
        ctl.active  = (state == issue) || (state == exec);
    end

    //================================================================
    // requester feedback
    //================================================================
    // one cycle finish pulse on the granted port
    assign finish = (state == done) ? ptr_onehot : '0;

    // master busy mirrored one cycle late, granted port only
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            busy_q <= m_busy ? ptr_onehot : '0;
        end
    end

    assign busy = busy_q;

endmodule

`default_nettype wire

//--- src/spi_req_mux.sv
//====================================================================
// latches the granted port's request fields and presents the
// registered request to the spi master
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module spi_req_mux (
    input  wire                     m0,
    input  wire                     rst_n,
    input  spi_arb_pkg::grant_ctl_t ctl,
    input  spi_req_pkg::req_arr_t   req,
    output logic                    m_request,
    output spi_req_pkg::spi_req_t   m_req
);

    import spi_req_pkg::*;

    // fields of the port being granted
    spi_req_t cap_q;

    // taken in the scan cycle that finds the request,
    // dropped once the issue state is over
    always_ff @(posedge m0) begin
        if (ctl.capture) begin
            cap_q <= req[ctl.port];
        end else if (!ctl.issue) begin
            cap_q <= '0;
        end
    end

    //================================================================
    // master request
    //================================================================
    // both follow the issue state by one register stage so the
    // fields are valid exactly while m_request is high
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            m_request <= 1'b0;
            m_req     <= '0;
        end else begin
            m_request <= ctl.issue;
            m_req     <= ctl.issue ? cap_q : '0;
        end
    end

endmodule

`default_nettype wire

//--- src/spi_wr_path.sv
//====================================================================
// write stream from the granted requester to the spi master through
// a one-entry valid/ready stage
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module spi_wr_path (
    input  wire                     m0,
    input  wire                     rst_n,
    input  spi_arb_pkg::grant_ctl_t ctl,
    input  spi_arb_pkg::port_vec_t  wr_vld,
    input  spi_req_pkg::data_arr_t  wr_data,
    output spi_arb_pkg::port_vec_t  wr_ready,
    output logic                    m_wr_vld,
    output spi_req_pkg::data_t      m_wr_data,
    input  wire                     m_wr_ready
);

    import spi_req_pkg::*;

    logic  stage_vld;
    data_t stage_data;
    logic  in_vld;
    logic  in_ready;
    logic  take;
    logic  drain;

    // only the granted port's stream is looked at
    assign in_vld   = ctl.active && wr_vld[ctl.port];
    // room when empty or when the master takes the held beat
    assign drain    = stage_vld && m_wr_ready;
    assign in_ready = ctl.active && (!stage_vld || m_wr_ready);
    assign take     = in_vld && in_ready;

    // ready back to the granted port, others held off
    always_comb begin
        wr_ready           = '0;
        wr_ready[ctl.port] = in_ready;
    end

    //================================================================
    // stage
    //================================================================
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            stage_vld <= 1'b0;
        end else if (take) begin
            stage_vld <= 1'b1;
        end else if (drain) begin
            stage_vld <= 1'b0;
        end
    end

    always_ff @(posedge m0) begin
        if (take) begin
            stage_data <= wr_data[ctl.port];
        end
    end

    assign m_wr_vld  = stage_vld;
    assign m_wr_data = stage_data;

endmodule

`default_nettype wire

//--- src/spi_rd_path.sv
//====================================================================
// read stream from the spi master back to the granted requester
// through a one-entry valid/ready stage
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module spi_rd_path (
    input  wire                     m0,
    input  wire                     rst_n,
    input  spi_arb_pkg::grant_ctl_t ctl,
    input  wire                     m_rd_vld,
    input  spi_req_pkg::data_t      m_rd_data,
    output logic                    m_rd_ready,
    output spi_arb_pkg::port_vec_t  rd_vld,
    output spi_req_pkg::data_arr_t  rd_data,
    input  spi_arb_pkg::port_vec_t  rd_ready
);

    import spi_arb_pkg::*;
    import spi_req_pkg::*;

    logic      stage_vld;
    data_t     stage_data;
    // port the held beat belongs to
    port_idx_t stage_port;
    logic      take;
    logic      drain;

    // the last beat can still sit here after the grant has ended,
    // so it drains to the port it was taken for
    assign drain      = stage_vld && rd_ready[stage_port];
    // master held off outside a grant
    assign m_rd_ready = ctl.active && (!stage_vld || rd_ready[stage_port]);
    assign take       = m_rd_vld && m_rd_ready;

    //================================================================
    // stage
    //================================================================
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            stage_vld  <= 1'b0;
            stage_port <= '0;
        end else if (take) begin
            stage_vld  <= 1'b1;
            stage_port <= ctl.port;
        end else if (drain) begin
            stage_vld  <= 1'b0;
        end
    end

    always_ff @(posedge m0) begin
        if (take) begin
            stage_data <= m_rd_data;
        end
    end

    //================================================================
    // fan out
    //================================================================
    // beat shows on one port only, every other port reads zero
    always_comb begin
        rd_vld  = '0;
        rd_data = '0;
        if (stage_vld) begin
            rd_vld[stage_port]  = 1'b1;
            rd_data[stage_port] = stage_data;
        end
    end

endmodule

`default_nettype wire

//--- src/spi_req_interconnect.sv
//====================================================================
// top level, eight spi requesters sharing one spi master engine by
// round-robin grant
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module spi_req_interconnect (
    input  wire                    m0,
    input  wire                    rst_n,
    // requester side
    input  spi_arb_pkg::port_vec_t request,
    input  spi_req_pkg::req_arr_t  req,
    output spi_arb_pkg::port_vec_t finish,
    output spi_arb_pkg::port_vec_t busy,
    input  spi_arb_pkg::port_vec_t wr_vld,
    input  spi_req_pkg::data_arr_t wr_data,
    output spi_arb_pkg::port_vec_t wr_ready,
    output spi_arb_pkg::port_vec_t rd_vld,
    output spi_req_pkg::data_arr_t rd_data,
    input  spi_arb_pkg::port_vec_t rd_ready,
    // master side
    output wire                    m_request,
    output spi_req_pkg::spi_req_t  m_req,
    input  wire                    m_busy,
    output wire                    m_wr_vld,
    output spi_req_pkg::data_t     m_wr_data,
    input  wire                    m_wr_ready,
    input  wire                    m_rd_vld,
    input  spi_req_pkg::data_t     m_rd_data,
    output wire                    m_rd_ready
);

    import spi_arb_pkg::*;

    // grant state to the three datapath blocks
    grant_ctl_t ctl;

    spi_grant_ctrl i_spi_grant_ctrl (
        .m0      (m0),
        .rst_n   (rst_n),
        .request (request),
        .m_busy  (m_busy),
        .ctl     (ctl),
        .finish  (finish),
        .busy    (busy)
    );

    spi_req_mux i_spi_req_mux (
        .m0        (m0),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .req       (req),
        .m_request (m_request),
        .m_req     (m_req)
    );

    spi_wr_path i_spi_wr_path (
        .m0         (m0),
        .rst_n      (rst_n),
        .ctl        (ctl),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .wr_ready   (wr_ready),
        .m_wr_vld   (m_wr_vld),
        .m_wr_data  (m_wr_data),
        .m_wr_ready (m_wr_ready)
    );

    spi_rd_path i_spi_rd_path (
        .m0         (m0),
        .rst_n      (rst_n),
        .ctl        (ctl),
        .m_rd_vld   (m_rd_vld),
        .m_rd_data  (m_rd_data),
        .m_rd_ready (m_rd_ready),
        .rd_vld     (rd_vld),
        .rd_data    (rd_data),
        .rd_ready   (rd_ready)
    );

endmodule

`default_nettype wire

//--- test/spi_ic_checker.sv
//====================================================================
// testbench checker that follows the grant rules cycle by cycle and
// scoreboards both data streams with one summary line per test
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module spi_ic_checker (
    input  wire                    m0,
    input  wire                    rst_n,
    input  spi_arb_pkg::port_vec_t request,
    input  spi_req_pkg::req_arr_t  req,
    input  spi_arb_pkg::port_vec_t finish,
    input  spi_arb_pkg::port_vec_t busy,
    input  spi_arb_pkg::port_vec_t wr_vld,
    input  spi_req_pkg::data_arr_t wr_data,
    input  spi_arb_pkg::port_vec_t wr_ready,
    input  spi_arb_pkg::port_vec_t rd_vld,
    input  spi_req_pkg::data_arr_t rd_data,
    input  spi_arb_pkg::port_vec_t rd_ready,
    input  wire                    m_request,
    input  spi_req_pkg::spi_req_t  m_req,
    input  wire                    m_busy,
    input  wire                    m_wr_vld,
    input  spi_req_pkg::data_t     m_wr_data,
    input  wire                    m_wr_ready,
    input  wire                    m_rd_vld,
    input  spi_req_pkg::data_t     m_rd_data,
    input  wire                    m_rd_ready,
    output int                     errors
);

    import spi_arb_pkg::*;
    import spi_req_pkg::*;

    // read beat in flight and the port it was taken for
    typedef struct packed {
        port_idx_t port;
        data_t     data;
    } rd_beat_t;

    // reference controller
    grant_state_t st;
    port_idx_t    ptr;
    port_vec_t    exp_busy;
    logic         exp_mreq;
    spi_req_t     exp_fields;
    logic         was_reset;
    // stream scoreboards
    data_t        wr_q[$];
    rd_beat_t     rd_q[$];
    // per test counts
    int           n_grant;
    int           n_wr;
    int           n_rd;
    int           test_err;

    initial begin
        errors    = 0;
        test_err  = 0;
        n_grant   = 0;
        n_wr      = 0;
        n_rd      = 0;
        was_reset = 1'b0;
    end

    task automatic flag(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        errors++;
        test_err++;
    endtask

    task automatic close_test(input string name);
        $display("test %s: %0d grants, %0d write beats, %0d read beats, %0d errors",
                 name, n_grant, n_wr, n_rd, test_err);
        n_grant  = 0;
        n_wr     = 0;
        n_rd     = 0;
        test_err = 0;
    endtask

    //================================================================
    // cycle compare on values from before the edge
    //================================================================
    always @(posedge m0) begin
        port_vec_t onehot;
        port_vec_t exp_rd_vld;
        data_arr_t exp_rd_data;
        logic      active;
        data_t     exp_wr;
        rd_beat_t  head;
        onehot = port_vec_t'(1) << ptr;
        active = (st == issue) || (st == exec);
        if (!rst_n) begin
            // first edge can still show power-up values
            if (was_reset && {m_request, m_wr_vld, m_rd_ready, finish, busy, wr_ready,
                              rd_vld} !== '0) begin
                flag("a control output is active during reset");
            end
            was_reset  = 1'b1;
            st         = idle;
            ptr        = '0;
            exp_busy   = '0;
            exp_mreq   = 1'b0;
            exp_fields = '0;
            wr_q.delete();
            rd_q.delete();
        end else begin
            // grant handshake and busy mirror
            if (finish !== ((st == done) ? onehot : '0)) begin
                flag($sformatf("finish %b, expected %b", finish, (st == done) ? onehot : '0));
            end
            if (busy !== exp_busy) begin
                flag($sformatf("busy %b, expected %b", busy, exp_busy));
            end
            if (m_request !== exp_mreq || m_req !== (exp_mreq ? exp_fields : '0)) begin
                flag($sformatf("m_request %b m_req %h, expected %b %h", m_request, m_req,
                               exp_mreq, exp_mreq ? exp_fields : '0));
            end
            // write stream from the granted port only
            if ((wr_ready & ~(active ? onehot : '0)) !== '0) begin
                flag($sformatf("wr_ready %b outside the granted port", wr_ready));
            end
            // the one-entry stage holds exactly the beats not yet taken
            if (m_wr_vld !== (wr_q.size() != 0)) begin
                flag($sformatf("m_wr_vld %b with %0d write beats held", m_wr_vld,
                               wr_q.size()));
            end
            if (m_wr_vld && m_wr_ready) begin
                if (wr_q.size() == 0) begin
                    flag("master took a write beat that no port sent");
                end else begin
                    exp_wr = wr_q.pop_front();
                    if (m_wr_data !== exp_wr) begin
                        flag($sformatf("m_wr_data %h, expected %h", m_wr_data, exp_wr));
                    end
                    n_wr++;
                end
            end
            for (int p = 0; p < num_ports; p++) begin
                if (wr_vld[p] && wr_ready[p]) begin
                    wr_q.push_back(wr_data[p]);
                end
            end
            // read beats show on their own port only
            if (!active && m_rd_ready !== 1'b0) begin
                flag("m_rd_ready high outside a grant");
            end
            exp_rd_vld  = '0;
            exp_rd_data = '0;
            head        = '0;
            if (rd_q.size() != 0) begin
                head                   = rd_q[0];
                exp_rd_vld[head.port]  = 1'b1;
                exp_rd_data[head.port] = head.data;
            end
            if (rd_vld !== exp_rd_vld || rd_data !== exp_rd_data) begin
                flag($sformatf("rd_vld %b rd_data %h, expected %b %h", rd_vld, rd_data,
                               exp_rd_vld, exp_rd_data));
            end
            if (rd_q.size() != 0 && rd_vld[head.port] && rd_ready[head.port]) begin
                rd_q.delete(0);
                n_rd++;
            end
            if (m_rd_vld && m_rd_ready) begin
                rd_q.push_back({ptr, m_rd_data});
            end
            // step the reference controller
            exp_mreq = (st == issue);
            exp_busy = m_busy ? onehot : '0;
            case (st)
                idle: st = scan;
                scan: begin
                    if (request[ptr]) begin
                        exp_fields = req[ptr];
                        st         = issue;
                    end else begin
                        ptr = ptr + port_idx_t'(1);
                    end
                end
                issue: if (m_busy) st = exec;
                exec:  if (!m_busy) st = done;
                default: begin
                    st  = scan;
                    ptr = ptr + port_idx_t'(1);
                    n_grant++;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- test/tb_spi_req_interconnect.sv
//====================================================================
// testbench for the spi requester interconnect with random requesters
// and a spi master model around the DUT, checked by spi_ic_checker
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_spi_req_interconnect;

    import spi_arb_pkg::*;
    import spi_req_pkg::*;

    // longest any single wait may take in cycles
    localparam int tmo = 2000;

    logic      m0;
    logic      rst_n;
    // requester side
    port_vec_t request;
    req_arr_t  req;
    port_vec_t finish;
    port_vec_t busy;
    port_vec_t wr_vld;
    data_arr_t wr_data;
    port_vec_t wr_ready;
    port_vec_t rd_vld;
    data_arr_t rd_data;
    port_vec_t rd_ready;
    // master side
    logic      m_request;
    spi_req_t  m_req;
    logic      m_busy;
    logic      m_wr_vld;
    data_t     m_wr_data;
    logic      m_wr_ready;
    logic      m_rd_vld;
    data_t     m_rd_data;
    logic      m_rd_ready;
    // run status
    int        errors;
    int        timeouts;
    int        tests;
    logic      run_done;

    spi_req_interconnect i_spi_req_interconnect (.*);

    spi_ic_checker i_spi_ic_checker (.*);

    initial begin
        m0 = 1'b0;
        forever #50 m0 = ~m0;
    end

    task automatic report_timeout(input string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, tmo);
        timeouts++;
    endtask

    task automatic end_test(input string name);
        tests++;
        i_spi_ic_checker.close_test(name);
    endtask

    //================================================================
    // requester doing count transfers of up to max_len beats each way
    //================================================================
    task automatic serve_port(input int p, input int count, input int max_len);
        spi_req_t f;
        int       sent;
        int       guard;
        logic     fin;
        logic     moved;
        repeat (count) begin
            f.req_len    = len_t'($urandom_range(max_len, 0));
            f.req_wr_len = len_t'($urandom_range(max_len, 0));
            f.req_cmd    = cmd_t'($urandom);
            @(negedge m0);
            req[p]     = f;
            request[p] = 1'b1;
            wr_data[p] = data_t'($urandom);
            wr_vld[p]  = (f.req_wr_len != 0);
            sent       = 0;
            guard      = 0;
            fin        = 1'b0;
            while (!fin && guard < tmo) begin
                rd_ready[p] = ($urandom_range(1, 0) != 0);
                @(posedge m0);
                fin   = finish[p];
                moved = wr_vld[p] && wr_ready[p];
                @(negedge m0);
                guard++;
                // next beat only once the current one has moved
                if (moved) begin
                    sent++;
                    wr_data[p] = data_t'($urandom);
                    wr_vld[p]  = (sent < f.req_wr_len);
                end
            end
            if (!fin) begin
                report_timeout($sformatf("finish on port %0d", p));
            end
            // late read beat still drains while idle
            request[p]  = 1'b0;
            req[p]      = '0;
            wr_vld[p]   = 1'b0;
            rd_ready[p] = 1'b1;
            repeat ($urandom_range(2, 0)) @(negedge m0);
        end
    endtask

    //================================================================
    // spi master model
    //================================================================
    initial begin
        spi_req_t f;
        int       n;
        int       guard;
        int       idle_cycles;
        logic     moved;
        m_busy      = 1'b0;
        m_wr_ready  = 1'b0;
        m_rd_vld    = 1'b0;
        m_rd_data   = '0;
        idle_cycles = 0;
        forever begin
            @(negedge m0);
            if (!m_request) begin
                idle_cycles++;
                if (idle_cycles == tmo && !run_done) begin
                    report_timeout("m_request");
                end
            end else begin
                idle_cycles = 0;
                f           = m_req;
                repeat ($urandom_range(3, 0)) @(negedge m0);
                // busy lasts at least one cycle
                m_busy = 1'b1;
                @(negedge m0);
                n     = 0;
                guard = 0;
                while (n < f.req_wr_len && guard < tmo) begin
                    m_wr_ready = ($urandom_range(1, 0) != 0);
                    @(posedge m0);
                    moved = m_wr_vld && m_wr_ready;
                    @(negedge m0);
                    guard++;
                    if (moved) n++;
                end
                m_wr_ready = 1'b0;
                // read data held until taken
                n         = 0;
                m_rd_data = data_t'($urandom);
                while (n < f.req_len && guard < tmo) begin
                    m_rd_vld = 1'b1;
                    @(posedge m0);
                    moved = m_rd_ready;
                    @(negedge m0);
                    guard++;
                    if (moved) begin
                        n++;
                        m_rd_data = data_t'($urandom);
                    end
                end
                m_rd_vld = 1'b0;
                if (guard >= tmo) begin
                    report_timeout("end of the master write and read beats");
                end
                m_busy = 1'b0;
            end
        end
    end

    //================================================================
    // test sequence
    //================================================================
    initial begin
        int unsigned seed;
        int unsigned first_draw;
        seed       = 32'h94a7_7b10;
        first_draw = $urandom(seed);
        timeouts   = 0;
        tests      = 0;
        run_done   = 1'b0;
        rst_n      = 1'b0;
        request    = '0;
        req        = '0;
        wr_vld     = '0;
        wr_data    = '0;
        rd_ready   = '1;
        repeat (5) @(negedge m0);
        rst_n = 1'b1;
        repeat (3) @(negedge m0);
        end_test("reset state");
        // first draw picks the lone requester
        serve_port(first_draw % num_ports, 1, 4);
        end_test("single grant");
        // every port keeps requesting
        fork
            serve_port(0, 3, 3);
            serve_port(1, 3, 3);
            serve_port(2, 3, 3);
            serve_port(3, 3, 3);
            serve_port(4, 3, 3);
            serve_port(5, 3, 3);
            serve_port(6, 3, 3);
            serve_port(7, 3, 3);
        join
        end_test("round robin");
        fork
            serve_port(1, 2, 16);
            serve_port(4, 2, 16);
            serve_port(6, 2, 16);
        join
        end_test("long streams");
        run_done = 1'b1;
        $display("summary: %0d tests, %0d errors, %0d timeouts", tests, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
src/spi_arb_pkg.sv
src/spi_req_pkg.sv
src/spi_grant_ctrl.sv
src/spi_req_mux.sv
src/spi_wr_path.sv
src/spi_rd_path.sv
src/spi_req_interconnect.sv
test/spi_ic_checker.sv
test/tb_spi_req_interconnect.sv

//--- Bender.yml
package:
  name: spi_req_interconnect

sources:
  - src/spi_arb_pkg.sv
  - src/spi_req_pkg.sv
  - src/spi_grant_ctrl.sv
  - src/spi_req_mux.sv
  - src/spi_wr_path.sv
  - src/spi_rd_path.sv
  - src/spi_req_interconnect.sv
  - target: test
    files:
      - test/spi_ic_checker.sv
      - test/tb_spi_req_interconnect.sv
